// ==== verilog/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// instruction and pc width
`define FETCH_XLEN        16
// slots per fetch bundle
`define FETCH_WAYS        4

//////////////////////////////////////////////////////////////////////
// storage and limits
//////////////////////////////////////////////////////////////////////

// instruction ram, in words
`define FETCH_IMEM_DEPTH  256
// bimodal counters, indexed by low pc bits
`define FETCH_BP_ENTRIES  16
// unresolved branches allowed past fetch
`define FETCH_MAX_BRANCH  2

`endif

// ==== verilog/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

   // major opcode, instruction bits 15..12
   // branches need bits 15..14 = 10 and a nonzero 13..12
   typedef enum logic [3:0] {
      op_alu = 4'd0,
      op_mem = 4'd8,
      op_beq = 4'd9,
      op_bne = 4'd10,
      op_blt = 4'd11,
      op_jmp = 4'd15
   } opcode_e;

   // register jump waiting for its target from the backend
   typedef enum logic {
      jw_run,
      jw_wait
   } jwait_e;

   // bundle to decode, slot i sits at pc + i
   typedef struct packed {
      logic [`FETCH_XLEN-1:0]                  pc;
      logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] words;
      logic                                    pred_lookup;
   } fetch_bundle_t;

   // predictor training from execute
   typedef struct packed {
      logic                   valid;
      logic [`FETCH_XLEN-1:0] pc;
      logic                   taken;
   } resolve_t;

   // mispredict or register jump target
   typedef struct packed {
      logic                   valid;
      logic [`FETCH_XLEN-1:0] pc;
   } redirect_t;

   // handler to next-pc, masks hold surviving slots only
   typedef struct packed {
      logic [`FETCH_WAYS-1:0] taken;
      logic [`FETCH_WAYS-1:0] imm_jump;
      logic [`FETCH_XLEN-1:0] fall_pc;
      logic                   pc_hold;
   } slot_info_t;

endpackage

// ==== verilog/fetch_imem.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_imem (
   input  logic                                    clk,
   input  logic                                    we,
   input  logic [`FETCH_XLEN-1:0]                  addr,
   input  logic [`FETCH_XLEN-1:0]                  wdata,
   input  logic [`FETCH_XLEN-1:0]                  rd_pc,
   output logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] rd_words
);

   localparam int AW = $clog2(`FETCH_IMEM_DEPTH);

   // word storage, filled through the load port
   logic [`FETCH_XLEN-1:0] mem [`FETCH_IMEM_DEPTH];
   logic [AW-1:0]          rd_base;
   logic [AW-1:0]          rd_addr [`FETCH_WAYS];

   //////////////////////////////////////////////////////////////////////
   // load port
   //////////////////////////////////////////////////////////////////////

   // upper address bits ignored, depth is a power of two
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr[AW-1:0]] <= wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // four-word read
   //////////////////////////////////////////////////////////////////////

   assign rd_base = rd_pc[AW-1:0];

   // consecutive words, wrap at the top of the array
   always_comb begin
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         rd_addr[i]  = rd_base + AW'(i);
         rd_words[i] = mem[rd_addr[i]];
      end
   end

endmodule

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_predictor (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`FETCH_XLEN-1:0] fetch_pc,
   input  logic [`FETCH_WAYS-1:0] brnch_mask,
   input  fetch_pkg::resolve_t    resolve,
   output logic [1:0]             pred_to_pcsel
);

   localparam int         IDX_W   = $clog2(`FETCH_BP_ENTRIES);
   localparam int         SLOT_W  = $clog2(`FETCH_WAYS);
   // weakly not taken
   localparam logic [1:0] CTR_INIT = 2'b01;

   logic [1:0]        ctr [`FETCH_BP_ENTRIES];
   logic              have_a;
   logic              have_b;
   logic [SLOT_W-1:0] slot_a;
   logic [SLOT_W-1:0] slot_b;
   logic [IDX_W-1:0]  idx_a;
   logic [IDX_W-1:0]  idx_b;
   logic [IDX_W-1:0]  idx_res;
   logic [1:0]        ctr_res;

   //////////////////////////////////////////////////////////////////////
   // lookup
   //////////////////////////////////////////////////////////////////////

   // first two branch slots of the bundle
   always_comb begin
      have_a = 1'b0;
      have_b = 1'b0;
      slot_a = '0;
      slot_b = '0;
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         if (brnch_mask[i]) begin
            if (!have_a) begin
               have_a = 1'b1;
               slot_a = SLOT_W'(i);
            end else if (!have_b) begin
               have_b = 1'b1;
               slot_b = SLOT_W'(i);
            end
         end
      end
   end

   // each branch indexed by its own pc
   assign idx_a = fetch_pc[IDX_W-1:0] + IDX_W'(slot_a);
   assign idx_b = fetch_pc[IDX_W-1:0] + IDX_W'(slot_b);

   // bit 1 first branch, bit 0 second
   assign pred_to_pcsel = {have_a & ctr[idx_a][1], have_b & ctr[idx_b][1]};

   //////////////////////////////////////////////////////////////////////
   // training
   //////////////////////////////////////////////////////////////////////

   assign idx_res = resolve.pc[IDX_W-1:0];
   assign ctr_res = ctr[idx_res];

   // saturating 2-bit counters
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int e = 0; e < `FETCH_BP_ENTRIES; e++) begin
            ctr[e] <= CTR_INIT;
         end
      end else if (resolve.valid) begin
         if (resolve.taken && ctr_res != 2'b11) begin
            ctr[idx_res] <= ctr_res + 2'd1;
         end else if (!resolve.taken && ctr_res != 2'b00) begin
            ctr[idx_res] <= ctr_res - 2'd1;
         end
      end
   end

endmodule

// ==== verilog/branch_handler.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_handler (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic [`FETCH_XLEN-1:0]                  pc,
   input  logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] words,
   input  logic                                    stall_for_jump,
   input  logic                                    stall_fetch,
   input  logic                                    branch_retire,
   input  logic                                    mispred_two,
   input  logic [1:0]                              pred_to_pcsel,
   output logic [`FETCH_WAYS-1:0]                  brnch_mask,
   output fetch_pkg::slot_info_t                   slots,
   output fetch_pkg::fetch_bundle_t                bundle,
   output logic                                    brch_full
);

   import fetch_pkg::*;

   localparam int CNT_W = $clog2(`FETCH_MAX_BRANCH + 1);
   // ordinals need headroom past the limit
   localparam int ORD_W = CNT_W + 1;

   opcode_e                op         [`FETCH_WAYS];
   logic [`FETCH_WAYS-1:0] is_jump;
   logic [`FETCH_WAYS-1:0] is_imm;
   logic [`FETCH_WAYS-1:0] over_limit;
   logic [`FETCH_WAYS-1:0] tkn_raw;
   logic [`FETCH_WAYS-1:0] kill_in;
   logic [`FETCH_WAYS-1:0] kill;
   logic [`FETCH_WAYS-1:0] limit_slot;
   logic [ORD_W-1:0]       ord_local  [`FETCH_WAYS];
   logic [ORD_W-1:0]       ord_total  [`FETCH_WAYS];
   logic [ORD_W-1:0]       n_surv;
   logic [CNT_W-1:0]       brnch_cnt;
   logic [CNT_W-1:0]       cnt_dec;
   logic                   hold_for_brnch;
   logic                   blocked;
   logic                   hit_limit;
   logic [`FETCH_XLEN-1:0] limit_off;

   //////////////////////////////////////////////////////////////////////
   // slot decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         op[i]         = opcode_e'(words[i][15:12]);
         is_jump[i]    = (op[i] == op_jmp);
         // bits 1..0 zero means target is in the word
         is_imm[i]     = is_jump[i] && (words[i][1:0] == 2'b00);
         brnch_mask[i] = op[i] inside {op_beq, op_bne, op_blt};
      end
   end

   // branches ahead of each slot, in bundle and overall
   always_comb begin
      ord_local[0] = '0;
      for (int i = 1; i < `FETCH_WAYS; i++) begin
         ord_local[i] = ord_local[i-1] + ORD_W'(brnch_mask[i-1]);
      end
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         ord_total[i]  = ord_local[i] + ORD_W'(brnch_cnt);
         over_limit[i] = brnch_mask[i] && (ord_total[i] >= ORD_W'(`FETCH_MAX_BRANCH));
         // predictor only covers the first two branches
         tkn_raw[i]    = brnch_mask[i] &&
                         ((ord_local[i] == ORD_W'(0) && pred_to_pcsel[1]) ||
                          (ord_local[i] == ORD_W'(1) && pred_to_pcsel[0]));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // nop chain
   //////////////////////////////////////////////////////////////////////

   // whole bundle dropped
   assign blocked = stall_fetch || stall_for_jump || hold_for_brnch;

   // once a slot dies every later slot dies
   always_comb begin
      kill_in[0] = blocked;
      kill[0]    = blocked || over_limit[0];
      for (int i = 1; i < `FETCH_WAYS; i++) begin
         kill_in[i] = kill[i-1] || is_jump[i-1] || tkn_raw[i-1];
         kill[i]    = kill_in[i] || over_limit[i];
      end
   end

   // third branch that is the actual flush point
   assign limit_slot = over_limit & ~kill_in;
   assign hit_limit  = |limit_slot;

   always_comb begin
      limit_off = `FETCH_XLEN'(`FETCH_WAYS);
      for (int i = `FETCH_WAYS - 1; i >= 0; i--) begin
         if (limit_slot[i]) begin
            limit_off = `FETCH_XLEN'(i);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // in-flight branch count
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      n_surv = '0;
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         n_surv = n_surv + ORD_W'(brnch_mask[i] && !kill[i]);
      end
   end

   // retire drops one, two on a double mispredict
   always_comb begin
      cnt_dec = '0;
      if (branch_retire) begin
         cnt_dec = mispred_two ? CNT_W'(2) : CNT_W'(1);
         if (cnt_dec > brnch_cnt) begin
            cnt_dec = brnch_cnt;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         brnch_cnt      <= '0;
         hold_for_brnch <= 1'b0;
      end else begin
         brnch_cnt <= brnch_cnt - cnt_dec + CNT_W'(n_surv);
         // retire wins, the flushed branch is refetched
         if (branch_retire) begin
            hold_for_brnch <= 1'b0;
         end else if (hit_limit) begin
            hold_for_brnch <= 1'b1;
         end
      end
   end

   assign brch_full = hold_for_brnch;

   //////////////////////////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      bundle.pc          = pc;
      bundle.pred_lookup = |(brnch_mask & ~kill);
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         bundle.words[i] = kill[i] ? '0 : words[i];
      end
   end

   // fall-through stops at a flushed third branch
   assign slots = '{taken:    tkn_raw & ~kill,
                    imm_jump: is_imm & ~kill,
                    fall_pc:  pc + limit_off,
                    pc_hold:  hold_for_brnch};

endmodule

// ==== verilog/next_pc.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module next_pc (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic [`FETCH_XLEN-1:0]                  pc,
   input  logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] words,
   input  fetch_pkg::slot_info_t                   slots,
   input  logic                                    stall_fetch,
   input  fetch_pkg::redirect_t                    redirect,
   output logic [`FETCH_XLEN-1:0]                  fetch_pc,
   output logic                                    stall_for_jump
);

   import fetch_pkg::*;

   jwait_e                 state;
   jwait_e                 state_nxt;
   logic                   br_hit;
   logic                   jmp_hit;
   logic                   jmp_seen;
   logic                   reg_jump;
   logic [`FETCH_XLEN-1:0] br_target;
   logic [`FETCH_XLEN-1:0] jmp_target;
   logic [`FETCH_XLEN-1:0] pc_nxt;

   //////////////////////////////////////////////////////////////////////
   // targets
   //////////////////////////////////////////////////////////////////////

   // scan downward so the lowest slot wins
   always_comb begin
      br_hit     = 1'b0;
      jmp_hit    = 1'b0;
      br_target  = '0;
      jmp_target = '0;
      for (int i = `FETCH_WAYS - 1; i >= 0; i--) begin
         if (slots.taken[i]) begin
            br_hit    = 1'b1;
            // slot pc plus signed 8-bit offset
            br_target = pc + `FETCH_XLEN'(i) +
                        {{(`FETCH_XLEN - 8){words[i][7]}}, words[i][7:0]};
         end
         if (slots.imm_jump[i]) begin
            jmp_hit    = 1'b1;
            jmp_target = `FETCH_XLEN'(words[i][11:2]);
         end
      end
   end

   // words come in already nop'd, so any jump left survived
   always_comb begin
      jmp_seen = 1'b0;
      reg_jump = 1'b0;
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         if (!jmp_seen && opcode_e'(words[i][15:12]) == op_jmp) begin
            jmp_seen = 1'b1;
            reg_jump = (words[i][1:0] != 2'b00);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // pc select and jump wait
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (redirect.valid) begin
         pc_nxt = redirect.pc;
      end else if (stall_fetch || slots.pc_hold || state == jw_wait) begin
         pc_nxt = fetch_pc;
      end else if (br_hit) begin
         pc_nxt = br_target;
      end else if (jmp_hit) begin
         pc_nxt = jmp_target;
      end else begin
         pc_nxt = slots.fall_pc;
      end
   end

   // wait for the register target, a redirect ends it
   always_comb begin
      state_nxt = state;
      if (redirect.valid) begin
         state_nxt = jw_run;
      end else if (state == jw_run && reg_jump) begin
         state_nxt = jw_wait;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_pc <= '0;
         state    <= jw_run;
      end else begin
         fetch_pc <= pc_nxt;
         state    <= state_nxt;
      end
   end

   assign stall_for_jump = (state == jw_wait);

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     imem_we,
   input  logic [`FETCH_XLEN-1:0]   imem_addr,
   input  logic [`FETCH_XLEN-1:0]   imem_wdata,
   input  logic                     stall_fetch,
   input  logic                     branch_retire,
   input  logic                     mispred_two,
   input  fetch_pkg::resolve_t      resolve,
   input  fetch_pkg::redirect_t     redirect,
   output fetch_pkg::fetch_bundle_t bundle,
   output logic                     brch_full
);

   import fetch_pkg::*;

   logic [`FETCH_XLEN-1:0]                  fetch_pc;
   // raw words straight from the ram
   logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] imem_words;
   logic [`FETCH_WAYS-1:0]                  brnch_mask;
   logic [1:0]                              pred_to_pcsel;
   slot_info_t                              slots;
   logic                                    stall_for_jump;

   //////////////////////////////////////////////////////////////////////
   // fetch path
   //////////////////////////////////////////////////////////////////////

   fetch_imem u_fetch_imem (
      .clk      (clk),
      .we       (imem_we),
      .addr     (imem_addr),
      .wdata    (imem_wdata),
      .rd_pc    (fetch_pc),
      .rd_words (imem_words)
   );

   branch_predictor u_branch_predictor (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_pc      (fetch_pc),
      .brnch_mask    (brnch_mask),
      .resolve       (resolve),
      .pred_to_pcsel (pred_to_pcsel)
   );

   branch_handler u_branch_handler (
      .clk            (clk),
      .rst_n          (rst_n),
      .pc             (fetch_pc),
      .words          (imem_words),
      .stall_for_jump (stall_for_jump),
      .stall_fetch    (stall_fetch),
      .branch_retire  (branch_retire),
      .mispred_two    (mispred_two),
      .pred_to_pcsel  (pred_to_pcsel),
      .brnch_mask     (brnch_mask),
      .slots          (slots),
      .bundle         (bundle),
      .brch_full      (brch_full)
   );

   // next-pc reads the nop'd bundle, only survivors steer it
   next_pc u_next_pc (
      .clk            (clk),
      .rst_n          (rst_n),
      .pc             (bundle.pc),
      .words          (bundle.words),
      .slots          (slots),
      .stall_fetch    (stall_fetch),
      .redirect       (redirect),
      .fetch_pc       (fetch_pc),
      .stall_for_jump (stall_for_jump)
   );

endmodule

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit_tb;

   import fetch_pkg::*;

   // six tests of at most about 40 cycles plus reset and margin
   localparam int CYCLE_LIMIT = 400;

   // slot 0 in the low word
   typedef logic [`FETCH_WAYS-1:0][`FETCH_XLEN-1:0] quad_t;

   logic                   clk;
   logic                   rst_n;
   logic                   imem_we;
   logic [`FETCH_XLEN-1:0] imem_addr;
   logic [`FETCH_XLEN-1:0] imem_wdata;
   logic                   stall_fetch;
   logic                   branch_retire;
   logic                   mispred_two;
   resolve_t               resolve;
   redirect_t              redirect;
   fetch_bundle_t          bundle;
   logic                   brch_full;

   int                     cycle_cnt = 0;
   int                     err_cnt = 0;
   int                     err_mark = 0;
   int                     pass_cnt = 0;
   int                     fail_cnt = 0;
   // words queued for the next load burst
   logic [`FETCH_XLEN-1:0] prog [$];

   fetch_unit u_fetch_unit (
      .clk           (clk),
      .rst_n         (rst_n),
      .imem_we       (imem_we),
      .imem_addr     (imem_addr),
      .imem_wdata    (imem_wdata),
      .stall_fetch   (stall_fetch),
      .branch_retire (branch_retire),
      .mispred_two   (mispred_two),
      .resolve       (resolve),
      .redirect      (redirect),
      .bundle        (bundle),
      .brch_full     (brch_full)
   );

   //////////////////////////////////////////////////////////////////////
   // clock and run limit
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= CYCLE_LIMIT);
      $display("timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus and check helpers
   //////////////////////////////////////////////////////////////////////

   // top nibble zero keeps it an alu op and unique per address
   function automatic logic [15:0] alu_word(input logic [15:0] addr);
      return {4'h0, addr[7:0], 4'hc};
   endfunction

   function automatic quad_t filler_quad(input logic [15:0] base);
      quad_t q;
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         q[i] = alu_word(base + 16'(i));
      end
      return q;
   endfunction

   // slot pc plus sign-extended bits 7..0
   function automatic logic [15:0] branch_target(input logic [15:0] slot_pc,
                                                 input logic [15:0] word);
      return slot_pc + {{8{word[7]}}, word[7:0]};
   endfunction

   // inputs change on the falling edge
   task automatic tick;
      @(negedge clk);
   endtask

   // comb outputs are stable mid low phase
   task automatic settle;
      #5;
   endtask

   task automatic check_val(input logic [15:0] got, input logic [15:0] exp, input string what);
      assert (got === exp) else begin
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bundle(input logic [15:0] exp_pc, input quad_t exp_words,
                               input logic exp_lookup);
      check_val(bundle.pc, exp_pc, "bundle pc");
      for (int i = 0; i < `FETCH_WAYS; i++) begin
         check_val(bundle.words[i], exp_words[i], $sformatf("slot %0d word", i));
      end
      check_val(16'(bundle.pred_lookup), 16'(exp_lookup), "pred_lookup");
   endtask

   // one word per cycle through the write strobe
   task automatic load_block(input logic [15:0] base);
      for (int i = 0; i < prog.size(); i++) begin
         tick();
         imem_we    = 1'b1;
         imem_addr  = base + 16'(i);
         imem_wdata = prog[i];
      end
      tick();
      imem_we = 1'b0;
      prog.delete();
   endtask

   task automatic queue_filler(input logic [15:0] base, input int n);
      for (int i = 0; i < n; i++) begin
         prog.push_back(alu_word(base + 16'(i)));
      end
   endtask

   // redirect under stall and then let fetch run from target
   task automatic steer_and_release(input logic [15:0] target);
      tick();
      redirect = '{valid: 1'b1, pc: target};
      tick();
      redirect.valid = 1'b0;
      stall_fetch    = 1'b0;
   endtask

   // stall keeps unloaded words away from the handler state
   task automatic park_fetch;
      tick();
      stall_fetch = 1'b1;
   endtask

   task automatic retire_branches(input logic two);
      tick();
      branch_retire = 1'b1;
      mispred_two   = two;
      tick();
      branch_retire = 1'b0;
      mispred_two   = 1'b0;
   endtask

   // two taken resolves push the counter to strongly taken
   task automatic train_taken(input logic [15:0] br_pc);
      repeat (2) begin
         tick();
         resolve = '{valid: 1'b1, pc: br_pc, taken: 1'b1};
      end
      tick();
      resolve.valid = 1'b0;
   endtask

   task automatic start_test;
      err_mark = err_cnt;
   endtask

   task automatic close_test(input string name);
      if (err_cnt == err_mark) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: FAILED with %0d errors", name, err_cnt - err_mark);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic fetch_sequential;
      start_test();
      queue_filler(16'h0000, 12);
      load_block(16'h0000);
      steer_and_release(16'h0000);
      for (int b = 0; b < 3; b++) begin
         if (b > 0) begin
            tick();
         end
         settle();
         check_bundle(16'(4 * b), filler_quad(16'(4 * b)), 1'b0);
      end
      check_val(16'(brch_full), 16'h0, "brch_full");
      park_fetch();
      close_test("sequential fetch");
   endtask

   task automatic jump_immediate;
      logic [15:0] jmp_word;
      logic [15:0] target;
      jmp_word = 16'hf100;
      target   = {6'b0, jmp_word[11:2]};
      start_test();
      prog = '{alu_word(16'h0010), jmp_word, alu_word(16'h0012), alu_word(16'h0013)};
      load_block(16'h0010);
      queue_filler(target, 4);
      load_block(target);
      steer_and_release(16'h0010);
      settle();
      // slots after the jump are dropped
      check_bundle(16'h0010, {16'h0, 16'h0, jmp_word, alu_word(16'h0010)}, 1'b0);
      tick();
      settle();
      check_bundle(target, filler_quad(target), 1'b0);
      park_fetch();
      close_test("immediate jump");
   endtask

   task automatic branch_taken;
      logic [15:0] br_word;
      logic [15:0] target;
      // bne with a negative offset in slot 1
      br_word = 16'ha0e7;
      target  = branch_target(16'h0031, br_word);
      start_test();
      prog = '{alu_word(16'h0030), br_word, alu_word(16'h0032), alu_word(16'h0033)};
      load_block(16'h0030);
      queue_filler(target, 4);
      load_block(target);
      train_taken(16'h0031);
      steer_and_release(16'h0030);
      settle();
      check_bundle(16'h0030, {16'h0, 16'h0, br_word, alu_word(16'h0030)}, 1'b1);
      tick();
      settle();
      check_bundle(target, filler_quad(target), 1'b0);
      park_fetch();
      // the taken branch is still in flight
      retire_branches(1'b0);
      close_test("predicted-taken branch");
   endtask

   task automatic branch_limit;
      logic [15:0] third_pc;
      // low pc bits keep these away from the trained counter
      third_pc = 16'h0066;
      start_test();
      // fourth branch survives the refetch only once both retired
      prog = '{16'h9003, 16'ha005, 16'hb007, 16'h9002};
      queue_filler(16'h0068, 2);
      load_block(16'h0064);
      steer_and_release(16'h0064);
      settle();
      check_bundle(16'h0064, {16'h0, 16'h0, 16'ha005, 16'h9003}, 1'b1);
      check_val(16'(brch_full), 16'h0, "brch_full before limit");
      repeat (3) begin
         tick();
         settle();
         check_bundle(third_pc, '0, 1'b0);
         check_val(16'(brch_full), 16'h1, "brch_full while held");
      end
      tick();
      branch_retire = 1'b1;
      mispred_two   = 1'b1;
      settle();
      check_bundle(third_pc, '0, 1'b0);
      tick();
      branch_retire = 1'b0;
      mispred_two   = 1'b0;
      settle();
      // refetch starts at the flushed branch
      check_bundle(third_pc, {alu_word(16'h0069), alu_word(16'h0068), 16'h9002,
                              16'hb007}, 1'b1);
      check_val(16'(brch_full), 16'h0, "brch_full after retire");
      park_fetch();
      retire_branches(1'b1);
      close_test("branch limit");
   endtask

   task automatic decode_stall;
      start_test();
      queue_filler(16'h0080, 12);
      load_block(16'h0080);
      steer_and_release(16'h0080);
      settle();
      check_bundle(16'h0080, filler_quad(16'h0080), 1'b0);
      repeat (3) begin
         tick();
         stall_fetch = 1'b1;
         settle();
         check_bundle(16'h0084, '0, 1'b0);
      end
      tick();
      stall_fetch = 1'b0;
      settle();
      check_bundle(16'h0084, filler_quad(16'h0084), 1'b0);
      tick();
      settle();
      check_bundle(16'h0088, filler_quad(16'h0088), 1'b0);
      park_fetch();
      close_test("decode stall");
   endtask

   task automatic jump_register;
      start_test();
      prog = '{alu_word(16'h00a0), 16'hf001};
      load_block(16'h00a0);
      queue_filler(16'h00a2, 6);
      load_block(16'h00a2);
      queue_filler(16'h00c0, 4);
      load_block(16'h00c0);
      steer_and_release(16'h00a0);
      settle();
      check_bundle(16'h00a0, {16'h0, 16'h0, 16'hf001, alu_word(16'h00a0)}, 1'b0);
      // pc steps to fall-through once and then waits
      repeat (3) begin
         tick();
         settle();
         check_bundle(16'h00a4, '0, 1'b0);
      end
      tick();
      redirect = '{valid: 1'b1, pc: 16'h00c0};
      settle();
      check_bundle(16'h00a4, '0, 1'b0);
      tick();
      redirect.valid = 1'b0;
      settle();
      check_bundle(16'h00c0, filler_quad(16'h00c0), 1'b0);
      park_fetch();
      close_test("register jump");
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      rst_n         = 1'b0;
      imem_we       = 1'b0;
      imem_addr     = '0;
      imem_wdata    = '0;
      // fetch stays stalled until a program is loaded
      stall_fetch   = 1'b1;
      branch_retire = 1'b0;
      mispred_two   = 1'b0;
      resolve       = '0;
      redirect      = '0;
      repeat (8) @(posedge clk);
      tick();
      rst_n = 1'b1;
      fetch_sequential();
      jump_immediate();
      branch_taken();
      branch_limit();
      decode_stall();
      jump_register();
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_imem.sv
verilog/branch_predictor.sv
verilog/branch_handler.sv
verilog/next_pc.sv
verilog/fetch_unit.sv
bench/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module fetch_unit_tb -Mdir obj_dir -o fetch_unit_sim \
   -f flist.f || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/fetch_unit_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All tests passed" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
